/* ieu_pkg.sv */
/*
 * Shared widths, vector types, operation and size codes,
 * operation and data-bus structs, FSM state enums for the execute stage
 */
package ieu_pkg;

   localparam int DW     = 32;
   localparam int AW     = 32;
   localparam int REG_AW = 5;

   typedef logic [DW-1:0]     data_t;
   typedef logic [AW-1:0]     addr_t;
   typedef logic [AW-3:0]     pc_t;       // Word address
   typedef logic [REG_AW-1:0] reg_addr_t;
   typedef logic [3:0]        op_code_t;
   typedef logic [1:0]        mem_size_t;

   // Arithmetic unit
   localparam op_code_t OP_ADD     = 4'd0;
   localparam op_code_t OP_SUB     = 4'd1;
   localparam op_code_t OP_CMP_EQ  = 4'd2;
   localparam op_code_t OP_CMP_LT  = 4'd3;
   localparam op_code_t OP_CMP_LTU = 4'd4;
   // Logic and shift unit
   localparam op_code_t OP_AND     = 4'd5;
   localparam op_code_t OP_OR      = 4'd6;
   localparam op_code_t OP_XOR     = 4'd7;
   localparam op_code_t OP_SLL     = 4'd8;
   localparam op_code_t OP_SRL     = 4'd9;
   localparam op_code_t OP_SRA     = 4'd10;
   // Memory and branches
   localparam op_code_t OP_LOAD    = 4'd11;
   localparam op_code_t OP_STORE   = 4'd12;
   localparam op_code_t OP_JMPREL  = 4'd13;
   localparam op_code_t OP_JMPFAR  = 4'd14;

   localparam mem_size_t SIZE_BYTE = 2'd0;
   localparam mem_size_t SIZE_HALF = 2'd1;
   localparam mem_size_t SIZE_WORD = 2'd2;

   typedef struct packed {
      op_code_t  op;
      data_t     operand_1;
      data_t     operand_2;
      data_t     operand_3;   // Store data
      mem_size_t size;
      logic      sign_ext;
      logic      wb_en;
      reg_addr_t wb_addr;
      logic      link;        // Write link address instead of a result
      pc_t       insn_pc;
      logic      specul_bcc;  // Predicted branch outcome
      pc_t       specul_tgt;
   } ieu_op_t;

   typedef struct packed {
      addr_t     addr;
      data_t     wdata;
      mem_size_t size;
      logic      we;
   } dbus_req_t;

   typedef enum logic [1:0] {
      LSU_IDLE,
      LSU_REQ,
      LSU_WAIT
   } lsu_state_e;

   typedef enum logic {
      FLS_IDLE,
      FLS_HOLD
   } flush_state_e;

endpackage

/* ieu_arith.sv */
/*
 * Arithmetic unit: shared adder/subtractor, signed and unsigned
 * compares, condition flag register
 */
`timescale 1ns/1ps

module ieu_arith
   import ieu_pkg::*;
(
   input  logic    clk,
   input  logic    rst_n_i,
   input  ieu_op_t op_i,
   input  logic    commit_i,
   output logic    arith_sel_o,
   output data_t   arith_res_o,
   output logic    cc_o
);

   logic        is_cmp;
   logic        sub;
   data_t       opb;
   logic [DW:0] sum;
   logic        cmp_eq;
   logic        cmp_lt;
   logic        cmp_ltu;
   logic        cmp_res;
   logic        cc_q;

   assign is_cmp = (op_i.op == OP_CMP_EQ) | (op_i.op == OP_CMP_LT) |
                   (op_i.op == OP_CMP_LTU);
   assign arith_sel_o = (op_i.op == OP_ADD) | (op_i.op == OP_SUB) | is_cmp;

   // Compares reuse the subtractor
   assign sub = (op_i.op != OP_ADD);
   assign opb = op_i.operand_2 ^ {DW{sub}};
   assign sum = {1'b0, op_i.operand_1} + {1'b0, opb} + {{DW{1'b0}}, sub};

   assign cmp_eq  = (sum[DW-1:0] == '0);
   assign cmp_ltu = ~sum[DW];                     // Borrow out
   // Signs differ: the negative operand is the smaller one
   assign cmp_lt  = (op_i.operand_1[DW-1] ^ op_i.operand_2[DW-1]) ?
                    op_i.operand_1[DW-1] : sum[DW-1];

   always_comb begin
      unique case (op_i.op)
         OP_CMP_EQ:  cmp_res = cmp_eq;
         OP_CMP_LT:  cmp_res = cmp_lt;
         OP_CMP_LTU: cmp_res = cmp_ltu;
         default:    cmp_res = 1'b0;
      endcase
   end

   assign arith_res_o = is_cmp ? {{(DW-1){1'b0}}, cmp_res} : sum[DW-1:0];

   // Condition flag, read later by relative branches
   always_ff @(posedge clk or negedge rst_n_i) begin
      if (!rst_n_i) begin
         cc_q <= 1'b0;
      end else if (commit_i && is_cmp) begin
         cc_q <= cmp_res;
      end
   end

   assign cc_o = cc_q;

endmodule

/* ieu_logic.sv */
/*
 * Logic unit: and, or, xor and the three shifts
 */
`timescale 1ns/1ps

module ieu_logic
   import ieu_pkg::*;
(
   input  ieu_op_t op_i,
   output logic    logic_sel_o,
   output data_t   logic_res_o
);

   logic [4:0] shamt;
   data_t      a;
   data_t      b;

   assign a     = op_i.operand_1;
   assign b     = op_i.operand_2;
   assign shamt = b[4:0];             // Only the low 5 bits count

   always_comb begin
      logic_sel_o = 1'b1;
      unique case (op_i.op)
         OP_AND: logic_res_o = a & b;
         OP_OR:  logic_res_o = a | b;
         OP_XOR: logic_res_o = a ^ b;
         OP_SLL: logic_res_o = a << shamt;
         OP_SRL: logic_res_o = a >> shamt;
         // Sign bit fills from the left
         OP_SRA: logic_res_o = data_t'($signed(a) >>> shamt);
         default: begin
            logic_sel_o = 1'b0;
            logic_res_o = '0;
         end
      endcase
   end

endmodule

/* ieu_lsu.sv */
/*
 * Load/store unit: request FSM on the data bus,
 * store lane replication, load lane select and extension
 */
`timescale 1ns/1ps

module ieu_lsu
   import ieu_pkg::*;
(
   input  logic      clk,
   input  logic      rst_n_i,
   input  logic      op_valid_i,
   input  ieu_op_t   op_i,
   input  logic      hold_i,
   output logic      dbus_req_valid_o,
   output dbus_req_t dbus_req_o,
   input  logic      dbus_req_ready_i,
   input  logic      dbus_rsp_valid_i,
   input  data_t     dbus_rsp_data_i,
   output logic      mem_done_o,
   output data_t     load_data_o
);

   lsu_state_e state_q;
   lsu_state_e state_d;
   dbus_req_t  req_q;
   dbus_req_t  req_d;
   logic       is_mem;
   logic       start;
   logic [7:0]  rsp_byte;
   logic [15:0] rsp_half;

   assign is_mem = (op_i.op == OP_LOAD) | (op_i.op == OP_STORE);
   assign start  = op_valid_i & is_mem & ~hold_i;

   // Request built from the operation
   always_comb begin
      req_d.addr = op_i.operand_1 + op_i.operand_2;
      req_d.size = op_i.size;
      req_d.we   = (op_i.op == OP_STORE);
      unique case (op_i.size)
         SIZE_BYTE: req_d.wdata = {4{op_i.operand_3[7:0]}};
         SIZE_HALF: req_d.wdata = {2{op_i.operand_3[15:0]}};
         default:   req_d.wdata = op_i.operand_3;
      endcase
   end

   always_comb begin
      state_d = state_q;
      unique case (state_q)
         LSU_IDLE: if (start)            state_d = LSU_REQ;
         LSU_REQ:  if (dbus_req_ready_i) state_d = LSU_WAIT;
         LSU_WAIT: if (dbus_rsp_valid_i) state_d = LSU_IDLE;
         default:                        state_d = LSU_IDLE;
      endcase
   end

   always_ff @(posedge clk or negedge rst_n_i) begin
      if (!rst_n_i) begin
         state_q <= LSU_IDLE;
      end else begin
         state_q <= state_d;
      end
   end

   // Payload only, captured when leaving idle
   always_ff @(posedge clk) begin
      if (state_q == LSU_IDLE && start) begin
         req_q <= req_d;
      end
   end

   assign dbus_req_valid_o = (state_q == LSU_REQ);
   assign dbus_req_o       = req_q;
   assign mem_done_o       = (state_q == LSU_WAIT) & dbus_rsp_valid_i;

   // Lane select by the registered address
   always_comb begin
      unique case (req_q.addr[1:0])
         2'd0: rsp_byte = dbus_rsp_data_i[7:0];
         2'd1: rsp_byte = dbus_rsp_data_i[15:8];
         2'd2: rsp_byte = dbus_rsp_data_i[23:16];
         default: rsp_byte = dbus_rsp_data_i[31:24];
      endcase
      rsp_half = req_q.addr[1] ? dbus_rsp_data_i[31:16] : dbus_rsp_data_i[15:0];
   end

   always_comb begin
      unique case (req_q.size)
         SIZE_BYTE: load_data_o = {{24{op_i.sign_ext & rsp_byte[7]}}, rsp_byte};
         SIZE_HALF: load_data_o = {{16{op_i.sign_ext & rsp_half[15]}}, rsp_half};
         default:   load_data_o = dbus_rsp_data_i;
      endcase
   end

endmodule

/* ieu_branch_check.sv */
/*
 * Speculation check for relative branches and far jumps,
 * flush hold FSM with registered target, link address
 */
`timescale 1ns/1ps

module ieu_branch_check
   import ieu_pkg::*;
(
   input  logic    clk,
   input  logic    rst_n_i,
   input  ieu_op_t op_i,
   input  logic    commit_i,
   input  logic    cc_i,
   input  logic    flush_ack_i,
   output logic    flush_o,
   output pc_t     flush_tgt_o,
   output logic    flush_hold_o,
   output data_t   link_addr_o
);

   flush_state_e state_q;
   flush_state_e state_d;
   logic         is_rel;
   logic         is_far;
   pc_t          far_tgt;
   pc_t          tgt_d;
   pc_t          tgt_q;
   logic         mispredict;
   logic         flush_d;

   assign is_rel  = (op_i.op == OP_JMPREL);
   assign is_far  = (op_i.op == OP_JMPFAR);
   assign far_tgt = op_i.operand_1[AW-1:2];

   // Relative: outcome mismatch; far: target mismatch
   assign mispredict = (is_rel & (op_i.specul_bcc != cc_i)) |
                       (is_far & (op_i.specul_tgt != far_tgt));
   assign flush_d    = commit_i & mispredict;
   assign tgt_d      = is_far ? far_tgt : op_i.specul_tgt;

   always_comb begin
      state_d = state_q;
      unique case (state_q)
         FLS_IDLE: if (flush_d && !flush_ack_i) state_d = FLS_HOLD;
         FLS_HOLD: if (flush_ack_i)             state_d = FLS_IDLE;
         default:                               state_d = FLS_IDLE;
      endcase
   end

   always_ff @(posedge clk or negedge rst_n_i) begin
      if (!rst_n_i) begin
         state_q <= FLS_IDLE;
      end else begin
         state_q <= state_d;
      end
   end

   always_ff @(posedge clk) begin
      if (state_q == FLS_IDLE && flush_d) begin
         tgt_q <= tgt_d;                 // Kept until fetch acknowledges
      end
   end

   assign flush_hold_o = (state_q == FLS_HOLD);
   assign flush_o      = flush_hold_o | flush_d;
   assign flush_tgt_o  = flush_hold_o ? tgt_q : tgt_d;

   // Address of the next instruction
   assign link_addr_o = {op_i.insn_pc + 1'b1, 2'b00};

endmodule

/* ieu_top.sv */
/*
 * Integer execute stage top: unit instances, commit and ready,
 * register write-back select
 */
`timescale 1ns/1ps

module ieu_top
   import ieu_pkg::*;
(
   input  logic      clk,
   input  logic      rst_n_i,
   // Operation input
   input  logic      op_valid_i,
   output logic      op_ready_o,
   input  ieu_op_t   op_i,
   // Data bus
   output logic      dbus_req_valid_o,
   output dbus_req_t dbus_req_o,
   input  logic      dbus_req_ready_i,
   input  logic      dbus_rsp_valid_i,
   input  data_t     dbus_rsp_data_i,
   // Register file write port
   output logic      regf_we_o,
   output reg_addr_t regf_addr_o,
   output data_t     regf_data_o,
   // Flush to fetch
   output logic      flush_o,
   output pc_t       flush_tgt_o,
   input  logic      flush_ack_i
);

   logic  commit;
   logic  is_mem;
   logic  arith_sel;
   data_t arith_res;
   logic  cc;
   logic  logic_sel;
   data_t logic_res;
   logic  mem_done;
   data_t load_data;
   logic  flush_hold;
   data_t link_addr;

   ieu_arith u_arith (
      .clk         (clk),
      .rst_n_i     (rst_n_i),
      .op_i        (op_i),
      .commit_i    (commit),
      .arith_sel_o (arith_sel),
      .arith_res_o (arith_res),
      .cc_o        (cc)
   );

   ieu_logic u_logic (
      .op_i        (op_i),
      .logic_sel_o (logic_sel),
      .logic_res_o (logic_res)
   );

   ieu_lsu u_lsu (
      .clk              (clk),
      .rst_n_i          (rst_n_i),
      .op_valid_i       (op_valid_i),
      .op_i             (op_i),
      .hold_i           (flush_hold),
      .dbus_req_valid_o (dbus_req_valid_o),
      .dbus_req_o       (dbus_req_o),
      .dbus_req_ready_i (dbus_req_ready_i),
      .dbus_rsp_valid_i (dbus_rsp_valid_i),
      .dbus_rsp_data_i  (dbus_rsp_data_i),
      .mem_done_o       (mem_done),
      .load_data_o      (load_data)
   );

   ieu_branch_check u_branch_check (
      .clk          (clk),
      .rst_n_i      (rst_n_i),
      .op_i         (op_i),
      .commit_i     (commit),
      .cc_i         (cc),
      .flush_ack_i  (flush_ack_i),
      .flush_o      (flush_o),
      .flush_tgt_o  (flush_tgt_o),
      .flush_hold_o (flush_hold),
      .link_addr_o  (link_addr)
   );

   assign is_mem = (op_i.op == OP_LOAD) | (op_i.op == OP_STORE);

   // Memory ops wait for the bus response; nothing moves during a flush hold
   assign op_ready_o = ~flush_hold & (~is_mem | mem_done);
   assign commit     = op_valid_i & op_ready_o;

   // Link takes priority over the unit results
   always_comb begin
      if (op_i.link) begin
         regf_data_o = link_addr;
      end else if (arith_sel) begin
         regf_data_o = arith_res;
      end else if (logic_sel) begin
         regf_data_o = logic_res;
      end else if (op_i.op == OP_LOAD) begin
         regf_data_o = load_data;
      end else begin
         regf_data_o = '0;
      end
   end

   assign regf_addr_o = op_i.wb_addr;
   assign regf_we_o   = commit & op_i.wb_en & (op_i.op != OP_STORE);

endmodule

/* ieu_assertions.sv */
/*
 * Bound checks on the data-bus handshake, flush hold and register write
 */
`timescale 1ns/1ps

module ieu_assertions
   import ieu_pkg::*;
(
   input logic      clk,
   input logic      rst_n_i,
   input logic      req_valid_i,
   input logic      req_ready_i,
   input dbus_req_t req_i,
   input logic      rsp_valid_i,
   input ieu_op_t   op_i,
   input logic      op_ready_i,
   input logic      flush_i,
   input logic      flush_ack_i,
   input logic      regf_we_i
);

   // Request payload frozen until the bus takes it
   req_stable: assert property (@(posedge clk) disable iff (!rst_n_i)
      req_valid_i && !req_ready_i |=> $stable(req_i) && req_valid_i)
      else $error("dbus request changed while waiting for ready");

   // A flush without acknowledge is held in the next cycle
   hold_blocks_ready: assert property (@(posedge clk) disable iff (!rst_n_i)
      flush_i && !flush_ack_i |=> !op_ready_i)
      else $error("op_ready_o high during flush hold");

   // A load commits and writes back only with its response
   we_needs_commit: assert property (@(posedge clk) disable iff (!rst_n_i)
      regf_we_i && (op_i.op == OP_LOAD) |-> rsp_valid_i)
      else $error("register write without commit");

endmodule

bind ieu_top ieu_assertions u_assertions (
   .clk          (clk),
   .rst_n_i      (rst_n_i),
   .req_valid_i  (dbus_req_valid_o),
   .req_ready_i  (dbus_req_ready_i),
   .req_i        (dbus_req_o),
   .rsp_valid_i  (dbus_rsp_valid_i),
   .op_i         (op_i),
   .op_ready_i   (op_ready_o),
   .flush_i      (flush_o),
   .flush_ack_i  (flush_ack_i),
   .regf_we_i    (regf_we_o)
);

/* tb_ieu.sv */
/*
 * Testbench for the execute stage: operation table, data-bus memory model
 * with LFSR delays, flush acknowledge, compare tasks and watchdog
 */
`timescale 1ns/1ps

module tb_ieu
   import ieu_pkg::*;
;

   typedef struct packed {
      ieu_op_t   op;
      logic      exp_we;
      data_t     exp_data;
      logic      exp_flush;
      pc_t       exp_tgt;
      logic      has_req;
      dbus_req_t exp_req;
   } vec_t;

   logic      clk = 1'b0;
   logic      rst_n_i;
   logic      op_valid_i;
   logic      op_ready_o;
   ieu_op_t   op_i;
   logic      dbus_req_valid_o;
   dbus_req_t dbus_req_o;
   logic      dbus_req_ready_i;
   logic      dbus_rsp_valid_i;
   data_t     dbus_rsp_data_i;
   logic      regf_we_o;
   reg_addr_t regf_addr_o;
   data_t     regf_data_o;
   logic      flush_o;
   pc_t       flush_tgt_o;
   logic      flush_ack_i;

   vec_t      tbl[$];
   data_t     mem[256];
   dbus_req_t last_req;
   pc_t       held_tgt;      // Target expected while the flush is held
   int        req_count = 0;
   int        ack_count = 0;
   int        flush_count = 0;
   logic [31:0] lfsr = 32'h0ded2238;

   ieu_top dut0 (.*);

   always #20 clk = ~clk;

   // Galois LFSR, one step per bit taken
   function automatic logic [31:0] rand_bits(int n);
      logic [31:0] r;
      logic        b;
      r = '0;
      for (int k = 0; k < n; k++) begin
         b    = lfsr[0];
         lfsr = lfsr >> 1;
         if (b) lfsr = lfsr ^ 32'h80200003;
         r = {r[30:0], b};
      end
      return r;
   endfunction

   function automatic ieu_op_t make_op(op_code_t op, data_t a, data_t b, data_t c,
                                       mem_size_t sz, logic sx, reg_addr_t rd,
                                       logic link, pc_t pc, logic bcc, pc_t tgt);
      ieu_op_t o;
      o.op = op;
      o.operand_1 = a;
      o.operand_2 = b;
      o.operand_3 = c;
      o.size = sz;
      o.sign_ext = sx;
      o.wb_en = (rd != '0);
      o.wb_addr = rd;
      o.link = link;
      o.insn_pc = pc;
      o.specul_bcc = bcc;
      o.specul_tgt = tgt;
      return o;
   endfunction

   task automatic add_vec(ieu_op_t o, logic we, data_t d, logic fl, pc_t tgt,
                          logic hr, dbus_req_t rq);
      tbl.push_back('{o, we, d, fl, tgt, hr, rq});
   endtask

   task automatic stop_on_error(string msg);
      $display("** Error @%0t: %s", $time, msg);
      $display("TEST FAILED");
      $fatal(1, "check failed");
   endtask

   task automatic check_bit(string what, logic got, logic exp);
      if (got !== exp) stop_on_error($sformatf("%s got %b expected %b", what, got, exp));
   endtask

   task automatic check_data(string what, data_t got, data_t exp);
      if (got !== exp) stop_on_error($sformatf("%s got %h expected %h", what, got, exp));
   endtask

   task automatic check_reg(string what, reg_addr_t got, reg_addr_t exp);
      if (got !== exp) stop_on_error($sformatf("%s got %0d expected %0d", what, got, exp));
   endtask

   task automatic check_tgt(string what, pc_t got, pc_t exp);
      if (got !== exp) stop_on_error($sformatf("%s got %h expected %h", what, got, exp));
   endtask

   task automatic check_req(string what, dbus_req_t got, dbus_req_t exp);
      if (got !== exp) stop_on_error($sformatf("%s got %h expected %h", what, got, exp));
   endtask

   task automatic build_table();
      dbus_req_t nr;
      nr = '0;
      add_vec(make_op(OP_ADD, 5, 7, 0, SIZE_WORD, 0, 1, 0, 0, 0, 0), 1, 12, 0, 0, 0, nr);
      add_vec(make_op(OP_SUB, 3, 5, 0, SIZE_WORD, 0, 2, 0, 0, 0, 0), 1, 32'hFFFF_FFFE, 0, 0,
              0, nr);
      add_vec(make_op(OP_AND, 32'hF0F0_1234, 32'h0FF0_FF00, 0, SIZE_WORD, 0, 3, 0, 0, 0, 0),
              1, 32'h00F0_1200, 0, 0, 0, nr);
      add_vec(make_op(OP_OR, 32'hF0F0_1234, 32'h0FF0_FF00, 0, SIZE_WORD, 0, 4, 0, 0, 0, 0),
              1, 32'hFFF0_FF34, 0, 0, 0, nr);
      add_vec(make_op(OP_XOR, 32'hF0F0_1234, 32'h0FF0_FF00, 0, SIZE_WORD, 0, 5, 0, 0, 0, 0),
              1, 32'hFF00_ED34, 0, 0, 0, nr);
      add_vec(make_op(OP_SLL, 3, 32'h24, 0, SIZE_WORD, 0, 6, 0, 0, 0, 0), 1, 32'h30, 0, 0, 0, nr);
      add_vec(make_op(OP_SRL, 32'h8000_0000, 31, 0, SIZE_WORD, 0, 7, 0, 0, 0, 0), 1, 1, 0, 0,
              0, nr);
      add_vec(make_op(OP_SRA, 32'h8000_0010, 4, 0, SIZE_WORD, 0, 8, 0, 0, 0, 0),
              1, 32'hF800_0001, 0, 0, 0, nr);
      // Negative versus positive splits signed and unsigned
      add_vec(make_op(OP_CMP_LT, 32'hFFFF_FFFF, 1, 0, SIZE_WORD, 0, 9, 0, 0, 0, 0), 1, 1, 0, 0,
              0, nr);
      add_vec(make_op(OP_CMP_LTU, 32'hFFFF_FFFF, 1, 0, SIZE_WORD, 0, 10, 0, 0, 0, 0), 1, 0, 0, 0,
              0, nr);
      add_vec(make_op(OP_CMP_LTU, 1, 32'hFFFF_FFFF, 0, SIZE_WORD, 0, 23, 0, 0, 0, 0), 1, 1, 0,
              0, 0, nr);
      add_vec(make_op(OP_STORE, 32'h100, 4, 32'h8081_7F02, SIZE_WORD, 0, 0, 0, 0, 0, 0),
              0, 0, 0, 0, 1, '{32'h104, 32'h8081_7F02, SIZE_WORD, 1'b1});
      add_vec(make_op(OP_LOAD, 32'h100, 7, 0, SIZE_BYTE, 1, 11, 0, 0, 0, 0),
              1, 32'hFFFF_FF80, 0, 0, 1, '{32'h107, 32'h0, SIZE_BYTE, 1'b0});
      add_vec(make_op(OP_LOAD, 32'h100, 7, 0, SIZE_BYTE, 0, 12, 0, 0, 0, 0),
              1, 32'h80, 0, 0, 1, '{32'h107, 32'h0, SIZE_BYTE, 1'b0});
      add_vec(make_op(OP_LOAD, 32'h100, 5, 0, SIZE_BYTE, 1, 13, 0, 0, 0, 0),
              1, 32'h7F, 0, 0, 1, '{32'h105, 32'h0, SIZE_BYTE, 1'b0});
      add_vec(make_op(OP_LOAD, 32'h100, 6, 0, SIZE_HALF, 1, 14, 0, 0, 0, 0),
              1, 32'hFFFF_8081, 0, 0, 1, '{32'h106, 32'h0, SIZE_HALF, 1'b0});
      add_vec(make_op(OP_LOAD, 32'h100, 4, 0, SIZE_HALF, 0, 15, 0, 0, 0, 0),
              1, 32'h7F02, 0, 0, 1, '{32'h104, 32'h0, SIZE_HALF, 1'b0});
      add_vec(make_op(OP_LOAD, 32'h100, 4, 0, SIZE_BYTE, 0, 21, 0, 0, 0, 0),
              1, 32'h02, 0, 0, 1, '{32'h104, 32'h0, SIZE_BYTE, 1'b0});
      add_vec(make_op(OP_LOAD, 32'h100, 6, 0, SIZE_BYTE, 1, 22, 0, 0, 0, 0),
              1, 32'hFFFF_FF81, 0, 0, 1, '{32'h106, 32'h0, SIZE_BYTE, 1'b0});
      add_vec(make_op(OP_STORE, 32'h100, 9, 32'h55C3, SIZE_BYTE, 0, 0, 0, 0, 0, 0),
              0, 0, 0, 0, 1, '{32'h109, 32'hC3C3_C3C3, SIZE_BYTE, 1'b1});
      add_vec(make_op(OP_STORE, 32'h100, 32'hE, 32'hBEEF, SIZE_HALF, 0, 0, 0, 0, 0, 0),
              0, 0, 0, 0, 1, '{32'h10E, 32'hBEEF_BEEF, SIZE_HALF, 1'b1});
      add_vec(make_op(OP_LOAD, 32'h100, 32'hE, 0, SIZE_HALF, 1, 16, 0, 0, 0, 0),
              1, 32'hFFFF_BEEF, 0, 0, 1, '{32'h10E, 32'h0, SIZE_HALF, 1'b0});
      // Fill word 0x42 with byte lane 1 replaced
      add_vec(make_op(OP_LOAD, 32'h100, 8, 0, SIZE_WORD, 0, 17, 0, 0, 0, 0),
              1, 32'hE742_C3BD, 0, 0, 1, '{32'h108, 32'h0, SIZE_WORD, 1'b0});
      add_vec(make_op(OP_CMP_LT, 5, 3, 0, SIZE_WORD, 0, 18, 0, 0, 0, 0), 1, 0, 0, 0, 0, nr);
      add_vec(make_op(OP_JMPREL, 0, 0, 0, SIZE_WORD, 0, 0, 0, 0, 0, 30'h77), 0, 0, 0, 0, 0, nr);
      add_vec(make_op(OP_CMP_EQ, 9, 9, 0, SIZE_WORD, 0, 19, 0, 0, 0, 0), 1, 1, 0, 0, 0, nr);
      add_vec(make_op(OP_JMPREL, 0, 0, 0, SIZE_WORD, 0, 0, 0, 0, 0, 30'h123),
              0, 0, 1, 30'h123, 0, nr);
      add_vec(make_op(OP_JMPFAR, 32'h4000, 0, 0, SIZE_WORD, 0, 31, 1, 30'h40, 0, 30'h1000),
              1, 32'h104, 0, 0, 0, nr);
      add_vec(make_op(OP_JMPFAR, 32'h8004, 0, 0, SIZE_WORD, 0, 30, 1, 30'h7F, 0, 30'h2000),
              1, 32'h200, 1, 30'h2001, 0, nr);
      add_vec(make_op(OP_ADD, 32'h10, 32'h20, 0, SIZE_WORD, 0, 20, 0, 0, 0, 0), 1, 32'h30, 0, 0,
              0, nr);
   endtask

   // Memory model on the data bus
   initial begin
      int     d;
      logic [7:0] idx;
      for (int i = 0; i < 256; i++) begin
         idx = i[7:0];
         mem[i] = {idx ^ 8'hA5, idx, 8'h3C, ~idx};
      end
      forever begin
         do @(negedge clk); while (!dbus_req_valid_o);
         d = rand_bits(2);
         repeat (d) @(posedge clk);
         @(posedge clk) dbus_req_ready_i <= 1'b1;
         @(negedge clk) last_req = dbus_req_o;
         @(posedge clk) dbus_req_ready_i <= 1'b0;
         req_count++;
         idx = last_req.addr[9:2];
         if (last_req.we) begin
            for (int l = 0; l < 4; l++) begin
               if (last_req.size == SIZE_WORD ||
                   (last_req.size == SIZE_HALF && l[1] == last_req.addr[1]) ||
                   (last_req.size == SIZE_BYTE && l[1:0] == last_req.addr[1:0]))
                  mem[idx][8*l +: 8] = last_req.wdata[8*l +: 8];
            end
         end
         d = rand_bits(2);
         repeat (d) @(posedge clk);
         dbus_rsp_valid_i <= 1'b1;
         dbus_rsp_data_i  <= last_req.we ? 32'h0 : mem[idx];
         @(posedge clk) dbus_rsp_valid_i <= 1'b0;
      end
   end

   // Fetch side acknowledges two cycles after a flush
   initial begin
      forever begin
         do @(negedge clk); while (!flush_o);
         @(negedge clk);
         check_bit("held flush_o", flush_o, 1'b1);
         check_tgt("held flush_tgt_o", flush_tgt_o, held_tgt);
         @(posedge clk) flush_ack_i <= 1'b1;
         ack_count++;
         @(posedge clk) flush_ack_i <= 1'b0;
      end
   end

   initial begin
      int   req_seen;
      logic pending_flush;
      rst_n_i = 1'b0;
      op_valid_i = 1'b0;
      op_i = '0;
      dbus_req_ready_i = 1'b0;
      dbus_rsp_valid_i = 1'b0;
      dbus_rsp_data_i = '0;
      flush_ack_i = 1'b0;
      pending_flush = 1'b0;
      build_table();
      fork
         begin
            #(tbl.size() * 20 * 40);
            $display("Timeout: the operation table did not finish in time");
            $display("TEST FAILED");
            $fatal(1, "watchdog expired");
         end
      join_none
      repeat (2) @(posedge clk);
      rst_n_i <= 1'b1;
      foreach (tbl[i]) begin
         req_seen = req_count;
         @(posedge clk);
         op_valid_i <= 1'b1;
         op_i       <= tbl[i].op;
         do @(negedge clk); while (!(op_valid_i && op_ready_o));
         if (pending_flush && ack_count != flush_count) begin
            $display("Operation %0d was accepted before the flush acknowledge", i);
            $display("TEST FAILED");
            $fatal(1, "early accept");
         end
         check_bit("regf_we_o", regf_we_o, tbl[i].exp_we);
         if (tbl[i].exp_we) begin
            check_reg("regf_addr_o", regf_addr_o, tbl[i].op.wb_addr);
            check_data("regf_data_o", regf_data_o, tbl[i].exp_data);
         end
         check_bit("flush_o", flush_o, tbl[i].exp_flush);
         if (tbl[i].exp_flush) begin
            check_tgt("flush_tgt_o", flush_tgt_o, tbl[i].exp_tgt);
            flush_count++;
            held_tgt = tbl[i].exp_tgt;
         end
         pending_flush = tbl[i].exp_flush;
         if (tbl[i].has_req) begin
            check_bit("request issued", req_count == req_seen + 1, 1'b1);
            check_req("dbus_req_o", last_req, tbl[i].exp_req);
         end
      end
      @(posedge clk) op_valid_i <= 1'b0;
      repeat (2) @(posedge clk);
      $display("TEST PASSED");
      $finish;
   end

endmodule

/* vlog.f */
ieu_pkg.sv
ieu_arith.sv
ieu_logic.sv
ieu_lsu.sv
ieu_branch_check.sv
ieu_top.sv
ieu_assertions.sv
tb_ieu.sv

/* Bender.yml */
package:
  name: ieu

sources:
  - files:
      - ieu_pkg.sv
      - ieu_arith.sv
      - ieu_logic.sv
      - ieu_lsu.sv
      - ieu_branch_check.sv
      - ieu_top.sv
  - target: test
    files:
      - ieu_assertions.sv
      - tb_ieu.sv
